// File: Makefile
TOP := ex_stage_tb
SRCS := $(filter-out +incdir+%,$(shell cat src.f)) ex_defs.svh

.PHONY: all run clean

all: run

obj_dir/V$(TOP): $(SRCS) src.f
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		--top-module $(TOP) -f src.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "test failed" sim.log || ! grep -q "test passed" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

// File: ex_alu.sv
`include "ex_defs.svh"
`default_nettype none

module ex_alu (
	input  logic [`EX_XLEN-1:0] srca,
	input  logic [`EX_XLEN-1:0] srcb,
	input  logic [`EX_SA_W-1:0] shamt,
	input  ex_pkg::alu_func_e   alu_func,
	input  ex_pkg::sft_func_e   sft_func,
	input  logic                count_ones,
	input  logic [1:0]          lsa_sa,
	output logic [`EX_XLEN-1:0] alu_out,
	output logic [`EX_XLEN-1:0] sft_out,
	output logic [`EX_XLEN-1:0] count_out,
	output logic [`EX_XLEN-1:0] lsa_out,
	output logic                ovf
);

	logic [`EX_XLEN-1:0] sum;
	logic [`EX_XLEN-1:0] diff;
	logic                add_ovf;
	logic                sub_ovf;
	logic                hit;

	assign sum  = srca + srcb;
	assign diff = srca - srcb;

	// Same-sign operands whose sum flips sign
	assign add_ovf = (srca[`EX_XLEN-1] == srcb[`EX_XLEN-1]) &&
		(sum[`EX_XLEN-1] != srca[`EX_XLEN-1]);
	assign sub_ovf = (srca[`EX_XLEN-1] != srcb[`EX_XLEN-1]) &&
		(diff[`EX_XLEN-1] != srca[`EX_XLEN-1]);

	always_comb begin
		ovf = 1'b0;
		case (alu_func)
			ex_pkg::alu_add: begin
				alu_out = sum;
				ovf = add_ovf;
			end
			ex_pkg::alu_addu: alu_out = sum;
			ex_pkg::alu_sub: begin
				alu_out = diff;
				ovf = sub_ovf;
			end
			ex_pkg::alu_subu: alu_out = diff;
			ex_pkg::alu_and:  alu_out = srca & srcb;
			ex_pkg::alu_or:   alu_out = srca | srcb;
			ex_pkg::alu_xor:  alu_out = srca ^ srcb;
			ex_pkg::alu_nor:  alu_out = ~(srca | srcb);
			ex_pkg::alu_slt:  alu_out = `EX_XLEN'($signed(srca) < $signed(srcb));
			ex_pkg::alu_sltu: alu_out = `EX_XLEN'(srca < srcb);
			// Immediate goes to the upper half
			ex_pkg::alu_lui:
				alu_out = {srcb[`EX_XLEN/2-1:0], {(`EX_XLEN/2){1'b0}}};
			default: alu_out = '0;
		endcase
	end

	// Barrel shifter, operand is srcb (rt)
	always_comb begin
		case (sft_func)
			ex_pkg::sft_sll: sft_out = srcb << shamt;
			ex_pkg::sft_srl: sft_out = srcb >> shamt;
			ex_pkg::sft_sra: sft_out = $signed(srcb) >>> shamt;
			default:         sft_out = '0;
		endcase
	end

	// Count leading ones or zeros of srca
	always_comb begin
		count_out = '0;
		hit = 1'b0;
		for (int i = `EX_XLEN - 1; i >= 0; i--) begin
			if (!hit && (srca[i] == count_ones))
				count_out = count_out + 1'b1;
			else
				hit = 1'b1;
		end
	end

	// Scale by 2, 4, 8 or 16 then add
	assign lsa_out = (srca << ({1'b0, lsa_sa} + 3'd1)) + srcb;

endmodule

`default_nettype wire

// File: ex_defs.svh
`ifndef EX_DEFS_SVH
`define EX_DEFS_SVH

// Data path width
`define EX_XLEN 32

// Shift amount width
`define EX_SA_W 5

// Iterations of the multiply/divide loop, one result bit each
`define EX_MD_ITER 32

`endif

// File: ex_muldiv.sv
`include "ex_defs.svh"
`default_nettype none

module ex_muldiv (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                md_start,
	input  ex_pkg::md_op_e      md_op,
	input  logic [`EX_XLEN-1:0] srca,
	input  logic [`EX_XLEN-1:0] srcb,
	output logic                md_busy,
	output logic                md_done,
	hilo_if.md                  hilo
);

	localparam int CNT_W = $clog2(`EX_MD_ITER);

	ex_pkg::md_state_e     state;
	logic [CNT_W-1:0]      cnt;

	// Working register: product or {remainder, quotient}
	logic [2*`EX_XLEN-1:0] work;
	logic [`EX_XLEN-1:0]   opnd;
	logic                  is_div;
	logic                  neg_q;
	logic                  neg_r;

	logic                  op_signed;
	logic                  op_div;
	logic                  sign_a;
	logic                  sign_b;
	logic [`EX_XLEN-1:0]   a_mag;
	logic [`EX_XLEN-1:0]   b_mag;
	logic [`EX_XLEN:0]     acc_sum;
	logic [`EX_XLEN:0]     part;
	logic [`EX_XLEN:0]     trial;
	logic                  ge;
	logic [2*`EX_XLEN-1:0] mul_nxt;
	logic [2*`EX_XLEN-1:0] div_nxt;
	logic [2*`EX_XLEN-1:0] prod_neg;

	assign op_signed = (md_op == ex_pkg::md_mult) || (md_op == ex_pkg::md_div);
	assign op_div    = (md_op == ex_pkg::md_div) || (md_op == ex_pkg::md_divu);
	assign sign_a    = op_signed && srca[`EX_XLEN-1];
	assign sign_b    = op_signed && srcb[`EX_XLEN-1];
	assign a_mag     = sign_a ? -srca : srca;
	assign b_mag     = sign_b ? -srcb : srcb;

	// Shift-and-add step, multiplier sits in the low half
	assign acc_sum = {1'b0, work[2*`EX_XLEN-1:`EX_XLEN]} + {1'b0, opnd};
	assign mul_nxt = work[0] ? {acc_sum, work[`EX_XLEN-1:1]} : {1'b0, work[2*`EX_XLEN-1:1]};

	// Restoring divide step, partial remainder needs one extra bit
	assign part    = work[2*`EX_XLEN-1:`EX_XLEN-1];
	assign ge      = part >= {1'b0, opnd};
	assign trial   = part - {1'b0, opnd};
	assign div_nxt = {ge ? trial[`EX_XLEN-1:0] : part[`EX_XLEN-1:0],
		work[`EX_XLEN-2:0], ge};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= ex_pkg::st_idle;
			cnt <= '0;
		end else begin
			case (state)
				ex_pkg::st_idle: begin
					if (md_start) begin
						state <= ex_pkg::st_run;
						cnt <= '0;
					end
				end
				ex_pkg::st_run: begin
					cnt <= cnt + 1'b1;
					if (cnt == CNT_W'(`EX_MD_ITER - 1))
						state <= ex_pkg::st_done;
				end
				ex_pkg::st_done: state <= ex_pkg::st_idle;
				default: state <= ex_pkg::st_idle;
			endcase
		end
	end

	// Operands captured at start, later input changes are ignored
	always_ff @(posedge clk) begin
		if (state == ex_pkg::st_idle && md_start) begin
			work <= {{`EX_XLEN{1'b0}}, op_div ? a_mag : b_mag};
			opnd <= op_div ? b_mag : a_mag;
			is_div <= op_div;
			neg_q <= sign_a ^ sign_b;
			neg_r <= sign_a;
		end else if (state == ex_pkg::st_run) begin
			work <= is_div ? div_nxt : mul_nxt;
		end
	end

	// Sign fix-up on the way out
	assign prod_neg = -work;

	always_comb begin
		if (is_div) begin
			hilo.md_hi = neg_r ? -work[2*`EX_XLEN-1:`EX_XLEN] : work[2*`EX_XLEN-1:`EX_XLEN];
			hilo.md_lo = neg_q ? -work[`EX_XLEN-1:0] : work[`EX_XLEN-1:0];
		end else begin
			hilo.md_hi = neg_q ? prod_neg[2*`EX_XLEN-1:`EX_XLEN] : work[2*`EX_XLEN-1:`EX_XLEN];
			hilo.md_lo = neg_q ? prod_neg[`EX_XLEN-1:0] : work[`EX_XLEN-1:0];
		end
	end

	assign md_busy     = (state == ex_pkg::st_run);
	assign md_done     = (state == ex_pkg::st_done);
	assign hilo.md_wen = (state == ex_pkg::st_done);

endmodule

`default_nettype wire

// File: ex_pkg.sv
`default_nettype none

package ex_pkg;

	// ALU operations
	typedef enum logic [3:0] {
		alu_add  = 4'd0,
		alu_addu = 4'd1,
		alu_sub  = 4'd2,
		alu_subu = 4'd3,
		alu_and  = 4'd4,
		alu_or   = 4'd5,
		alu_xor  = 4'd6,
		alu_nor  = 4'd7,
		alu_slt  = 4'd8,
		alu_sltu = 4'd9,
		alu_lui  = 4'd10
	} alu_func_e;

	// Shift operations, low bits of the MIPS funct field
	typedef enum logic [1:0] {
		sft_sll = 2'b00,
		sft_srl = 2'b10,
		sft_sra = 2'b11
	} sft_func_e;

	// Result select for the stage output
	typedef enum logic [2:0] {
		sel_alu   = 3'd0,
		sel_shift = 3'd1,
		sel_hi    = 3'd2,
		sel_lo    = 3'd3,
		sel_count = 3'd4,
		sel_rs    = 3'd5,
		sel_lsa   = 3'd6,
		sel_link  = 3'd7
	} out_sel_e;

	// Branch conditions
	typedef enum logic [2:0] {
		br_eq    = 3'd0,
		br_ne    = 3'd1,
		br_gez   = 3'd2,
		br_gtz   = 3'd3,
		br_lez   = 3'd4,
		br_ltz   = 3'd5,
		br_gezal = 3'd6,
		br_ltzal = 3'd7
	} branch_cond_e;

	typedef enum logic [1:0] {
		md_mult  = 2'd0,
		md_multu = 2'd1,
		md_div   = 2'd2,
		md_divu  = 2'd3
	} md_op_e;

	typedef enum logic [1:0] {
		st_idle = 2'd0,
		st_run  = 2'd1,
		st_done = 2'd2
	} md_state_e;

endpackage

`default_nettype wire

// File: ex_stage.sv
`include "ex_defs.svh"
`default_nettype none

module ex_stage (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic [`EX_XLEN-1:0]     rs_data,
	input  logic [`EX_XLEN-1:0]     rt_data,
	input  logic [15:0]             imm,
	input  logic [`EX_SA_W-1:0]     sa,
	input  logic [`EX_XLEN-1:0]     pc,
	input  logic                    imm_sign,
	input  logic                    srcb_imm,
	input  logic                    sft_var,
	input  logic                    count_ones,
	input  logic                    ovf_en,
	input  logic                    is_branch,
	input  logic                    guess_taken,
	input  logic                    md_start,
	input  logic                    mthi,
	input  logic                    mtlo,
	input  ex_pkg::alu_func_e       alu_func,
	input  ex_pkg::sft_func_e       sft_func,
	input  ex_pkg::out_sel_e        out_sel,
	input  ex_pkg::branch_cond_e    branch_cond,
	input  ex_pkg::md_op_e          md_op,
	output logic [`EX_XLEN-1:0]     result,
	output logic                    int_ovf,
	output logic                    branch_taken,
	output logic                    redirect,
	output logic                    md_busy,
	output logic                    md_done,
	output logic [`EX_XLEN-1:0]     hi,
	output logic [`EX_XLEN-1:0]     lo
);

	logic [`EX_XLEN-1:0] imm_ext;
	logic [`EX_XLEN-1:0] alu_srcb;
	logic [`EX_SA_W-1:0] shamt;
	logic [`EX_XLEN-1:0] alu_out;
	logic [`EX_XLEN-1:0] sft_out;
	logic [`EX_XLEN-1:0] count_out;
	logic [`EX_XLEN-1:0] lsa_out;
	logic [`EX_XLEN-1:0] link;
	logic                alu_ovf;
	logic                rs_eq_rt;
	logic                rs_zero;
	logic                rs_pos;
	logic                cond_met;

	hilo_if hilo_i ();

	// Zero or sign extension of the immediate
	assign imm_ext  = imm_sign ? {{(`EX_XLEN-16){imm[15]}}, imm} : {{(`EX_XLEN-16){1'b0}}, imm};
	assign alu_srcb = srcb_imm ? imm_ext : rt_data;
	assign shamt    = sft_var ? rs_data[`EX_SA_W-1:0] : sa;
	assign int_ovf  = alu_ovf & ovf_en;
	assign link     = pc + `EX_XLEN'd8;

	ex_alu alu_i (
		.srca       (rs_data),
		.srcb       (alu_srcb),
		.shamt      (shamt),
		.alu_func   (alu_func),
		.sft_func   (sft_func),
		.count_ones (count_ones),
		.lsa_sa     (sa[1:0]),
		.alu_out    (alu_out),
		.sft_out    (sft_out),
		.count_out  (count_out),
		.lsa_out    (lsa_out),
		.ovf        (alu_ovf)
	);

	ex_muldiv muldiv_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.md_start (md_start),
		.md_op    (md_op),
		.srca     (rs_data),
		.srcb     (rt_data),
		.md_busy  (md_busy),
		.md_done  (md_done),
		.hilo     (hilo_i.md)
	);

	hilo_regs hilo_regs_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.mthi    (mthi),
		.mtlo    (mtlo),
		.mt_data (rs_data),
		.hilo    (hilo_i.regs)
	);

	assign hi = hilo_i.hi;
	assign lo = hilo_i.lo;

	// Branch compare on rs alone except for eq/ne
	assign rs_eq_rt = (rs_data == rt_data);
	assign rs_zero  = (rs_data == '0);
	assign rs_pos   = ~rs_data[`EX_XLEN-1] & ~rs_zero;

	always_comb begin
		case (branch_cond)
			ex_pkg::br_eq:    cond_met = rs_eq_rt;
			ex_pkg::br_ne:    cond_met = !rs_eq_rt;
			ex_pkg::br_gez:   cond_met = rs_pos | rs_zero;
			ex_pkg::br_gtz:   cond_met = rs_pos;
			ex_pkg::br_lez:   cond_met = !rs_pos;
			ex_pkg::br_ltz:   cond_met = !rs_pos && !rs_zero;
			ex_pkg::br_gezal: cond_met = rs_pos | rs_zero;
			ex_pkg::br_ltzal: cond_met = !rs_pos && !rs_zero;
			default:          cond_met = 1'b0;
		endcase
	end

	assign branch_taken = is_branch && cond_met;
	// Mispredict in either direction
	assign redirect = branch_taken != guess_taken;

	always_comb begin
		case (out_sel)
			ex_pkg::sel_alu:   result = alu_out;
			ex_pkg::sel_shift: result = sft_out;
			ex_pkg::sel_hi:    result = hilo_i.hi;
			ex_pkg::sel_lo:    result = hilo_i.lo;
			ex_pkg::sel_count: result = count_out;
			ex_pkg::sel_rs:    result = rs_data;
			ex_pkg::sel_lsa:   result = lsa_out;
			ex_pkg::sel_link:  result = link;
			default:           result = alu_out;
		endcase
	end

endmodule

`default_nettype wire

// File: ex_stage_asserts.sv
`default_nettype none

module ex_stage_asserts (
	input wire clk,
	input wire rst_n,
	input wire md_busy,
	input wire md_done,
	input wire redirect,
	input wire is_branch,
	input wire guess_taken
);
	timeunit 1ns;
	timeprecision 100ps;

	// Done is a single-cycle pulse
	done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(md_done) |=> !md_done)
		else $error("md_done stayed high for more than one cycle");

	// End of a busy period always hands over to done
	busy_to_done: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(md_busy) |-> md_done)
		else $error("md_busy fell without md_done");

	redirect_src: assert property (@(posedge clk) disable iff (!rst_n)
		redirect |-> (is_branch || guess_taken))
		else $error("redirect high with neither is_branch nor guess_taken");

endmodule

bind ex_stage ex_stage_asserts ex_stage_asserts_i (
	.clk         (clk),
	.rst_n       (rst_n),
	.md_busy     (md_busy),
	.md_done     (md_done),
	.redirect    (redirect),
	.is_branch   (is_branch),
	.guess_taken (guess_taken)
);

`default_nettype wire

// File: ex_stage_tb.sv
`include "ex_defs.svh"
`default_nettype none

module ex_stage_tb;
	timeunit 1ns;
	timeprecision 100ps;

	logic                 clk;
	logic                 rst_n;
	logic [`EX_XLEN-1:0]  rs_data;
	logic [`EX_XLEN-1:0]  rt_data;
	logic [`EX_XLEN-1:0]  pc;
	logic [15:0]          imm;
	logic [`EX_SA_W-1:0]  sa;
	logic                 imm_sign;
	logic                 srcb_imm;
	logic                 sft_var;
	logic                 count_ones;
	logic                 ovf_en;
	logic                 is_branch;
	logic                 guess_taken;
	logic                 md_start;
	logic                 mthi;
	logic                 mtlo;
	ex_pkg::alu_func_e    alu_func;
	ex_pkg::sft_func_e    sft_func;
	ex_pkg::out_sel_e     out_sel;
	ex_pkg::branch_cond_e branch_cond;
	ex_pkg::md_op_e       md_op;
	logic [`EX_XLEN-1:0]  result;
	logic [`EX_XLEN-1:0]  hi;
	logic [`EX_XLEN-1:0]  lo;
	logic                 int_ovf;
	logic                 branch_taken;
	logic                 redirect;
	logic                 md_busy;
	logic                 md_done;
	int                   errors;
	int                   checks;
	int                   seed;

	tb_clkgen clkgen_i (
		.clk(clk)
	);

	ex_stage ex_stage_i (.*);

	// Inputs change 2 ns after the rising edge
	task automatic tick();
		@(posedge clk);
		#2;
	endtask

	task automatic check_word(input string name, input logic [`EX_XLEN-1:0] got,
		input logic [`EX_XLEN-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic do_reset();
		rst_n = 1'b0;
		repeat (2) tick();
		rst_n = 1'b1;
	endtask

	task automatic check_reset_state();
		check_word("hi", hi, '0);
		check_word("lo", lo, '0);
		check_bit("md_busy", md_busy, 1'b0);
		check_bit("md_done", md_done, 1'b0);
	endtask

	task automatic wait_done(output logic ok);
		int cycles;
		ok = 1'b0;
		cycles = 0;
		while (!ok && cycles < 100) begin
			tick();
			cycles++;
			ok = md_done;
		end
		if (!ok) begin
			errors++;
			$display("timeout at %0t: md_done never went high within 100 cycles", $time);
		end
	endtask

	function automatic logic [31:0] alu_expect(ex_pkg::alu_func_e f, logic [31:0] a,
		logic [31:0] b);
		case (f)
			ex_pkg::alu_add, ex_pkg::alu_addu: return a + b;
			ex_pkg::alu_sub, ex_pkg::alu_subu: return a - b;
			ex_pkg::alu_and:  return a & b;
			ex_pkg::alu_or:   return a | b;
			ex_pkg::alu_xor:  return a ^ b;
			ex_pkg::alu_nor:  return ~(a | b);
			ex_pkg::alu_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			ex_pkg::alu_sltu: return (a < b) ? 32'd1 : 32'd0;
			ex_pkg::alu_lui:  return {b[15:0], 16'h0000};
			default:          return 32'h0;
		endcase
	endfunction

	// Overflow when the 33-bit result disagrees in its top two bits
	function automatic logic ovf_expect(ex_pkg::alu_func_e f, logic [31:0] a, logic [31:0] b);
		logic [32:0] wide;
		wide = 33'h0;
		if (f == ex_pkg::alu_add)
			wide = {a[31], a} + {b[31], b};
		else if (f == ex_pkg::alu_sub)
			wide = {a[31], a} - {b[31], b};
		return wide[32] != wide[31];
	endfunction

	function automatic logic [31:0] lead_count(logic [31:0] a, logic ones);
		int n;
		n = 0;
		while (n < 32 && a[31 - n] == ones)
			n++;
		return n;
	endfunction

	function automatic logic cond_expect(ex_pkg::branch_cond_e c, logic [31:0] a,
		logic [31:0] b);
		logic signed [31:0] s;
		s = a;
		case (c)
			ex_pkg::br_eq:                    return a == b;
			ex_pkg::br_ne:                    return a != b;
			ex_pkg::br_gez, ex_pkg::br_gezal: return s >= 0;
			ex_pkg::br_gtz:                   return s > 0;
			ex_pkg::br_lez:                   return s <= 0;
			default:                          return s < 0;
		endcase
	endfunction

	task automatic md_expect(input ex_pkg::md_op_e op, input logic [31:0] a,
		input logic [31:0] b, output logic [31:0] eh, output logic [31:0] el);
		logic        sgn;
		logic [63:0] prod;
		logic [31:0] am;
		logic [31:0] bm;
		logic [31:0] q;
		logic [31:0] r;
		sgn = (op == ex_pkg::md_mult) || (op == ex_pkg::md_div);
		if (op == ex_pkg::md_mult || op == ex_pkg::md_multu) begin
			if (sgn)
				prod = {{32{a[31]}}, a} * {{32{b[31]}}, b};
			else
				prod = {32'h0, a} * {32'h0, b};
			eh = prod[63:32];
			el = prod[31:0];
		end else begin
			// Quotient and remainder on magnitudes with the signs applied afterwards
			am = (sgn && a[31]) ? -a : a;
			bm = (sgn && b[31]) ? -b : b;
			q = (bm == 32'h0) ? 32'hffffffff : am / bm;
			r = (bm == 32'h0) ? am : am % bm;
			eh = (sgn && a[31]) ? -r : r;
			el = (sgn && (a[31] ^ b[31])) ? -q : q;
		end
	endtask

	task automatic apply_alu(input ex_pkg::alu_func_e f, input logic [31:0] a,
		input logic [31:0] b, input logic use_imm, input logic sext, input logic oen);
		logic [31:0] opb;
		tick();
		alu_func = f;
		out_sel = ex_pkg::sel_alu;
		rs_data = a;
		rt_data = use_imm ? ~b : b;
		imm = b[15:0];
		srcb_imm = use_imm;
		imm_sign = sext;
		ovf_en = oen;
		#1;
		opb = use_imm ? (sext ? {{16{b[15]}}, b[15:0]} : {16'h0000, b[15:0]}) : b;
		check_word("result", result, alu_expect(f, a, opb));
		check_bit("int_ovf", int_ovf, oen && ovf_expect(f, a, opb));
	endtask

	task automatic apply_shift(input ex_pkg::sft_func_e f, input logic [31:0] b,
		input logic [4:0] n, input logic var_amt);
		logic [31:0] exp;
		tick();
		out_sel = ex_pkg::sel_shift;
		sft_func = f;
		srcb_imm = 1'b0;
		rt_data = b;
		sft_var = var_amt;
		sa = var_amt ? ~n : n;
		rs_data = {27'h2aaaaaa, var_amt ? n : ~n};
		case (f)
			ex_pkg::sft_sll: exp = b << n;
			ex_pkg::sft_srl: exp = b >> n;
			default:         exp = (b >> n) | (b[31] ? ~(32'hffffffff >> n) : 32'h0);
		endcase
		#1;
		check_word("result", result, exp);
	endtask

	task automatic apply_count(input logic [31:0] a, input logic ones);
		tick();
		out_sel = ex_pkg::sel_count;
		rs_data = a;
		count_ones = ones;
		#1;
		check_word("result", result, lead_count(a, ones));
	endtask

	task automatic apply_lsa(input logic [31:0] a, input logic [31:0] b, input logic [1:0] s);
		tick();
		out_sel = ex_pkg::sel_lsa;
		srcb_imm = 1'b0;
		rs_data = a;
		rt_data = b;
		sa = {3'b000, s};
		#1;
		check_word("result", result, a * (32'd2 << s) + b);
	endtask

	task automatic apply_branch(input ex_pkg::branch_cond_e c, input logic [31:0] a,
		input logic [31:0] b, input logic br, input logic guess);
		logic taken;
		tick();
		branch_cond = c;
		rs_data = a;
		rt_data = b;
		is_branch = br;
		guess_taken = guess;
		#1;
		taken = br && cond_expect(c, a, b);
		check_bit("branch_taken", branch_taken, taken);
		check_bit("redirect", redirect, taken != guess);
	endtask

	task automatic apply_md(input ex_pkg::md_op_e op, input logic [31:0] a,
		input logic [31:0] b, input logic restart, input logic mt_clash);
		logic [31:0] eh;
		logic [31:0] el;
		logic        ok;
		md_expect(op, a, b, eh, el);
		tick();
		md_op = op;
		rs_data = a;
		rt_data = b;
		md_start = 1'b1;
		tick();
		md_start = 1'b0;
		check_bit("md_busy", md_busy, 1'b1);
		// Operands already captured so the inputs are scrambled
		rs_data = $random(seed);
		rt_data = $random(seed);
		md_op = ex_pkg::md_op_e'(~op);
		if (restart) begin
			tick();
			md_start = 1'b1;
			tick();
			md_start = 1'b0;
			check_bit("md_busy", md_busy, 1'b1);
		end
		wait_done(ok);
		if (ok) begin
			if (mt_clash) begin
				rs_data = 32'h5a5a5a5a;
				mthi = 1'b1;
				mtlo = 1'b1;
			end
			tick();
			mthi = 1'b0;
			mtlo = 1'b0;
			check_word("hi", hi, eh);
			check_word("lo", lo, el);
			out_sel = ex_pkg::sel_hi;
			#1;
			check_word("result", result, eh);
			out_sel = ex_pkg::sel_lo;
			#1;
			check_word("result", result, el);
		end
	endtask

	task automatic test_alu();
		logic [31:0] a;
		logic [31:0] b;
		for (int i = 0; i < 11; i++) begin
			a = $random(seed);
			b = $random(seed);
			apply_alu(ex_pkg::alu_func_e'(i), a, b, 1'b0, 1'b0, 1'b1);
			apply_alu(ex_pkg::alu_func_e'(i), a, b, 1'b1, 1'b0, 1'b1);
			apply_alu(ex_pkg::alu_func_e'(i), a, b, 1'b1, 1'b1, 1'b1);
		end
		// Signed limits with the flag on and off
		apply_alu(ex_pkg::alu_add, 32'h7fffffff, 32'h1, 1'b0, 1'b0, 1'b1);
		apply_alu(ex_pkg::alu_add, 32'h7fffffff, 32'h1, 1'b0, 1'b0, 1'b0);
		apply_alu(ex_pkg::alu_add, 32'h80000000, 32'hffffffff, 1'b0, 1'b0, 1'b1);
		apply_alu(ex_pkg::alu_add, 32'h80000000, 32'h8000, 1'b1, 1'b1, 1'b1);
		apply_alu(ex_pkg::alu_sub, 32'h80000000, 32'h1, 1'b0, 1'b0, 1'b1);
		apply_alu(ex_pkg::alu_sub, 32'h7fffffff, 32'hffffffff, 1'b0, 1'b0, 1'b1);
		apply_alu(ex_pkg::alu_sub, 32'h7fffffff, 32'hffffffff, 1'b0, 1'b0, 1'b0);
		apply_alu(ex_pkg::alu_addu, 32'h7fffffff, 32'h1, 1'b0, 1'b0, 1'b1);
		apply_alu(ex_pkg::alu_subu, 32'h80000000, 32'h1, 1'b0, 1'b0, 1'b1);
	endtask

	task automatic test_shift_misc();
		logic [31:0] b;
		logic [4:0]  n;
		for (int k = 0; k < 8; k++) begin
			b = $random(seed);
			b[31] = k[0];
			n = (k == 0) ? 5'd0 : ((k == 7) ? 5'd31 : 5'($random(seed)));
			apply_shift(ex_pkg::sft_sll, b, n, k[1]);
			apply_shift(ex_pkg::sft_srl, b, n, k[1]);
			apply_shift(ex_pkg::sft_sra, b, n, k[1]);
		end
		apply_count(32'h00000000, 1'b0);
		apply_count(32'h00000000, 1'b1);
		apply_count(32'hffffffff, 1'b1);
		apply_count(32'hffffffff, 1'b0);
		for (int k = 0; k < 7; k++) begin
			b = 32'($random(seed)) >> (k * 5);
			apply_count(b, 1'b0);
			apply_count(~b, 1'b1);
		end
		for (int s = 0; s < 4; s++)
			apply_lsa($random(seed), $random(seed), 2'(s));
		// Link address
		tick();
		out_sel = ex_pkg::sel_link;
		pc = $random(seed);
		#1;
		check_word("result", result, pc + 32'd8);
		// Pass-through of rs
		b = $random(seed);
		tick();
		out_sel = ex_pkg::sel_rs;
		rs_data = b;
		#1;
		check_word("result", result, b);
	endtask

	task automatic test_branch();
		logic [31:0] ra [4];
		logic [31:0] rb [4];
		// Equal, negative, zero and positive rs
		ra = '{32'h00000042, 32'hfffffff0, 32'h00000000, 32'h00012345};
		rb = '{32'h00000042, 32'h00000001, 32'h00000009, 32'h00054321};
		for (int c = 0; c < 8; c++) begin
			for (int k = 0; k < 4; k++) begin
				apply_branch(ex_pkg::branch_cond_e'(c), ra[k], rb[k], 1'b1, 1'b0);
				apply_branch(ex_pkg::branch_cond_e'(c), ra[k], rb[k], 1'b1, 1'b1);
			end
		end
		apply_branch(ex_pkg::br_eq, 32'h1, 32'h1, 1'b0, 1'b0);
		apply_branch(ex_pkg::br_eq, 32'h1, 32'h1, 1'b0, 1'b1);
		is_branch = 1'b0;
		guess_taken = 1'b0;
	endtask

	task automatic test_muldiv();
		for (int k = 0; k < 4; k++) begin
			apply_md(ex_pkg::md_op_e'(k), $random(seed), $random(seed), 1'b0, 1'b0);
			apply_md(ex_pkg::md_op_e'(k), $random(seed), $random(seed), 1'b0, 1'b0);
			apply_md(ex_pkg::md_op_e'(k), 32'h80000000, 32'hffffffff, 1'b0, 1'b0);
			apply_md(ex_pkg::md_op_e'(k), 32'h80000000, 32'h00000000, 1'b0, 1'b0);
			apply_md(ex_pkg::md_op_e'(k), 32'hfffffff9, 32'h00000000, 1'b0, 1'b0);
			apply_md(ex_pkg::md_op_e'(k), 32'hfffffff9, 32'h00000002, 1'b0, 1'b0);
			apply_md(ex_pkg::md_op_e'(k), 32'h7fffffff, 32'h80000000, 1'b0, 1'b0);
		end
	endtask

	task automatic test_hilo_writes();
		logic [31:0] v;
		v = $random(seed);
		tick();
		rs_data = v;
		mthi = 1'b1;
		tick();
		mthi = 1'b0;
		check_word("hi", hi, v);
		rs_data = ~v;
		mtlo = 1'b1;
		tick();
		mtlo = 1'b0;
		check_word("lo", lo, ~v);
		check_word("hi", hi, v);
		// Ignored second start and then a move-to against the done write
		apply_md(ex_pkg::md_mult, 32'h00012345, 32'hfffff000, 1'b1, 1'b0);
		apply_md(ex_pkg::md_divu, 32'hcafef00d, 32'h00000123, 1'b0, 1'b1);
		// Reset in the middle of a divide
		tick();
		md_op = ex_pkg::md_div;
		md_start = 1'b1;
		tick();
		md_start = 1'b0;
		repeat (5) tick();
		do_reset();
		check_reset_state();
	endtask

	initial begin
		seed = 73273;
		errors = 0;
		checks = 0;
		rst_n = 1'b0;
		rs_data = '0;
		rt_data = '0;
		pc = '0;
		imm = '0;
		sa = '0;
		imm_sign = 1'b0;
		srcb_imm = 1'b0;
		sft_var = 1'b0;
		count_ones = 1'b0;
		ovf_en = 1'b0;
		is_branch = 1'b0;
		guess_taken = 1'b0;
		md_start = 1'b0;
		mthi = 1'b0;
		mtlo = 1'b0;
		alu_func = ex_pkg::alu_add;
		sft_func = ex_pkg::sft_sll;
		out_sel = ex_pkg::sel_alu;
		branch_cond = ex_pkg::br_eq;
		md_op = ex_pkg::md_mult;
		do_reset();
		check_reset_state();
		test_alu();
		test_shift_misc();
		test_branch();
		test_muldiv();
		test_hilo_writes();
		$display("checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: hilo_if.sv
`include "ex_defs.svh"
`default_nettype none

interface hilo_if;

	// Architectural HI/LO values
	logic [`EX_XLEN-1:0] hi;
	logic [`EX_XLEN-1:0] lo;

	// Multiply/divide result and its write strobe
	logic [`EX_XLEN-1:0] md_hi;
	logic [`EX_XLEN-1:0] md_lo;
	logic                md_wen;

	modport regs (output hi, output lo, input md_hi, input md_lo, input md_wen);

	modport md (input hi, input lo, output md_hi, output md_lo, output md_wen);

endinterface

`default_nettype wire

// File: hilo_regs.sv
`include "ex_defs.svh"
`default_nettype none

module hilo_regs (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                mthi,
	input  logic                mtlo,
	input  logic [`EX_XLEN-1:0] mt_data,
	hilo_if.regs                hilo
);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			hilo.hi <= '0;
			hilo.lo <= '0;
		end else if (hilo.md_wen) begin
			// Multiply/divide result beats a move-to in the same cycle
			hilo.hi <= hilo.md_hi;
			hilo.lo <= hilo.md_lo;
		end else begin
			if (mthi)
				hilo.hi <= mt_data;
			if (mtlo)
				hilo.lo <= mt_data;
		end
	end

endmodule

`default_nettype wire

// File: src.f
+incdir+.
ex_pkg.sv
hilo_if.sv
ex_alu.sv
ex_muldiv.sv
hilo_regs.sv
ex_stage.sv
tb_clkgen.sv
ex_stage_asserts.sv
ex_stage_tb.sv

// File: tb_clkgen.sv
`default_nettype none

module tb_clkgen (
	output logic clk
);
	timeunit 1ns;
	timeprecision 100ps;

	// 20 ns period, first rising edge at 10 ns
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

endmodule

`default_nettype wire
